/* verilog/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath width
`define CORE_XLEN 32

// reorder buffer entries, power of two
`define CORE_ROB_DEPTH 8

// architectural register count
`define CORE_ARCH_REGS 32

// multiplier cycles from issue to completion
`define CORE_MDU_LATENCY 4

`endif

/* verilog/core_pkg.sv */
`include "core_macros.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [$clog2(`CORE_ROB_DEPTH)-1:0] rob_idx_t;
  typedef logic [$clog2(`CORE_ARCH_REGS)-1:0] arch_reg_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_MUL,
    OP_TRAP
  } op_e;

  // decoded op with operand values already read
  typedef struct packed {
    op_e       op;
    word_t     pc;
    logic      dest_valid;
    arch_reg_t arch_dest;
    word_t     src0;
    word_t     src1;
  } dispatch_t;

  typedef struct packed {
    logic     valid;
    op_e      op;
    rob_idx_t rob_idx;
    word_t    src0;
    word_t    src1;
  } exe_req_t;

  // lane completion into the rob
  typedef struct packed {
    logic     valid;
    rob_idx_t rob_idx;
    word_t    value;
    logic     exception;
  } cmt_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    logic      dest_valid;
    arch_reg_t arch_dest;
    word_t     value;
    logic      exception;
  } retire_t;

endpackage

/* verilog/dispatch_stage.sv */
module dispatch_stage import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      dispatch_valid_i,
  input  dispatch_t dispatch_i,
  input  logic      rob_full_i,
  input  rob_idx_t  alloc_idx_i,
  input  logic      mdu_busy_i,
  input  logic      flush_i,
  output logic      dispatch_ready_o,
  output logic      alloc_valid_o,
  output dispatch_t alloc_entry_o,
  output exe_req_t  alu_req_o,
  output exe_req_t  mdu_req_o
);

  logic      hold_valid_q;
  dispatch_t hold_q;
  logic      hold_is_mul;
  logic      stall;
  logic      issue;

  assign hold_is_mul = hold_q.op == OP_MUL;
  // held op leaves in the same cycle a new one is taken
  assign stall            = rob_full_i | (hold_valid_q & hold_is_mul & mdu_busy_i);
  assign dispatch_ready_o = ~flush_i & ~stall;
  assign issue            = hold_valid_q & dispatch_ready_o;

  assign alloc_valid_o = issue;
  assign alloc_entry_o = hold_q;

  always_comb begin
    alu_req_o = '{valid: issue & ~hold_is_mul, op: hold_q.op, rob_idx: alloc_idx_i,
                  src0: hold_q.src0, src1: hold_q.src1};
    mdu_req_o = '{valid: issue & hold_is_mul, op: hold_q.op, rob_idx: alloc_idx_i,
                  src0: hold_q.src0, src1: hold_q.src1};
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_valid_q <= 1'b0;
    end else if (flush_i) begin
      hold_valid_q <= 1'b0;
    end else if (dispatch_ready_o) begin
      hold_valid_q <= dispatch_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dispatch_ready_o && dispatch_valid_i) begin
      hold_q <= dispatch_i;
    end
  end

endmodule

/* verilog/alu_unit.sv */
module alu_unit import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  exe_req_t req_i,
  input  logic     flush_i,
  output cmt_t     cmt_o
);

  word_t    result;
  logic     trap;
  logic     valid_q;
  rob_idx_t rob_idx_q;
  word_t    value_q;
  logic     exc_q;

  always_comb begin
    result = '0;
    trap   = 1'b0;
    case (req_i.op)
      OP_ADD:  result = req_i.src0 + req_i.src1;
      OP_SUB:  result = req_i.src0 - req_i.src1;
      OP_AND:  result = req_i.src0 & req_i.src1;
      OP_OR:   result = req_i.src0 | req_i.src1;
      OP_XOR:  result = req_i.src0 ^ req_i.src1;
      OP_SLT:  result = ($signed(req_i.src0) < $signed(req_i.src1)) ? word_t'(1) : '0;
      OP_TRAP: trap = 1'b1;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rob_idx_q <= req_i.rob_idx;
    value_q   <= result;
    exc_q     <= trap;
  end

  assign cmt_o = '{valid: valid_q, rob_idx: rob_idx_q, value: value_q, exception: exc_q};

endmodule

/* verilog/mdu_unit.sv */
`include "core_macros.svh"

module mdu_unit import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  exe_req_t req_i,
  input  logic     flush_i,
  output logic     busy_o,
  output cmt_t     cmt_o
);

  localparam int LATENCY = `CORE_MDU_LATENCY;
  localparam int CNT_W   = $clog2(LATENCY + 1);

  typedef enum logic {
    MDU_IDLE,
    MDU_BUSY
  } mdu_state_e;

  mdu_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;
  rob_idx_t         rob_idx_q;
  word_t            product_q;
  logic             done;

  assign busy_o = state_q == MDU_BUSY;
  // last busy cycle carries the result
  assign done   = busy_o && (cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= MDU_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= MDU_IDLE;
    end else if (req_i.valid) begin
      state_q <= MDU_BUSY;
      cnt_q   <= CNT_W'(LATENCY - 1);
    end else if (done) begin
      state_q <= MDU_IDLE;
    end else if (busy_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // low word of the product only
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rob_idx_q <= req_i.rob_idx;
      product_q <= req_i.src0 * req_i.src1;
    end
  end

  assign cmt_o = '{valid: done, rob_idx: rob_idx_q, value: product_q, exception: 1'b0};

  // dispatch holds multiplies back while a product is in flight
  a_no_req_when_busy: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) req_i.valid |-> !busy_o
  );

endmodule

/* verilog/reorder_buffer.sv */
`include "core_macros.svh"

module reorder_buffer import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      alloc_valid_i,
  input  dispatch_t alloc_entry_i,
  input  cmt_t      alu_cmt_i,
  input  cmt_t      mdu_cmt_i,
  output rob_idx_t  alloc_idx_o,
  output logic      rob_full_o,
  output retire_t   retire_o,
  output logic      flush_o
);

  localparam int DEPTH = `CORE_ROB_DEPTH;
  localparam int CNT_W = $clog2(DEPTH + 1);

  rob_idx_t         head_q;
  rob_idx_t         tail_q;
  logic [CNT_W-1:0] count_q;
  logic [DEPTH-1:0] alloc_q;
  logic [DEPTH-1:0] done_q;
  logic             retire_en;

  // entry payload
  word_t     pc_q         [DEPTH];
  logic      dest_valid_q [DEPTH];
  arch_reg_t arch_dest_q  [DEPTH];
  word_t     value_q      [DEPTH];
  logic      exc_q        [DEPTH];

  assign alloc_idx_o = tail_q;
  assign rob_full_o  = count_q == CNT_W'(DEPTH);
  assign retire_en   = alloc_q[head_q] & done_q[head_q];
  assign flush_o     = retire_en & exc_q[head_q];

  always_comb begin
    retire_o.valid      = retire_en;
    retire_o.pc         = pc_q[head_q];
    retire_o.dest_valid = dest_valid_q[head_q];
    retire_o.arch_dest  = arch_dest_q[head_q];
    retire_o.value      = value_q[head_q];
    retire_o.exception  = exc_q[head_q];
  end

  // ======================================================================
  // pointers and entry state
  // ======================================================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      alloc_q <= '0;
      done_q  <= '0;
    end else if (flush_o) begin
      // trap at head, drop everything younger
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      alloc_q <= '0;
      done_q  <= '0;
    end else begin
      if (retire_en) begin
        alloc_q[head_q] <= 1'b0;
        done_q[head_q]  <= 1'b0;
        head_q          <= head_q + rob_idx_t'(1);
      end
      if (alloc_valid_i) begin
        alloc_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
        tail_q          <= tail_q + rob_idx_t'(1);
      end
      if (alu_cmt_i.valid) begin
        done_q[alu_cmt_i.rob_idx] <= 1'b1;
      end
      if (mdu_cmt_i.valid) begin
        done_q[mdu_cmt_i.rob_idx] <= 1'b1;
      end
      count_q <= count_q + CNT_W'(alloc_valid_i) - CNT_W'(retire_en);
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_valid_i) begin
      pc_q[tail_q]         <= alloc_entry_i.pc;
      dest_valid_q[tail_q] <= alloc_entry_i.dest_valid;
      arch_dest_q[tail_q]  <= alloc_entry_i.arch_dest;
    end
    if (alu_cmt_i.valid) begin
      value_q[alu_cmt_i.rob_idx] <= alu_cmt_i.value;
      exc_q[alu_cmt_i.rob_idx]   <= alu_cmt_i.exception;
    end
    if (mdu_cmt_i.valid) begin
      value_q[mdu_cmt_i.rob_idx] <= mdu_cmt_i.value;
      exc_q[mdu_cmt_i.rob_idx]   <= mdu_cmt_i.exception;
    end
  end

  // rob must have a free slot for every allocation
  a_no_alloc_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) alloc_valid_i |-> !rob_full_o
  );

  // lanes only complete ops that dispatch allocated
  a_alu_cmt_allocated: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) alu_cmt_i.valid |-> alloc_q[alu_cmt_i.rob_idx]
  );

  a_mdu_cmt_allocated: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mdu_cmt_i.valid |-> alloc_q[mdu_cmt_i.rob_idx]
  );

endmodule

/* verilog/arch_reg_file.sv */
`include "core_macros.svh"

module arch_reg_file import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  retire_t   retire_i,
  input  arch_reg_t rd_addr_i,
  output word_t     rd_data_o
);

  word_t regs_q [`CORE_ARCH_REGS];
  logic  wr_en;

  // trapping ops leave the register state untouched
  assign wr_en = retire_i.valid & retire_i.dest_valid & ~retire_i.exception;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `CORE_ARCH_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[retire_i.arch_dest] <= retire_i.value;
    end
  end

  assign rd_data_o = regs_q[rd_addr_i];

endmodule

/* verilog/ooo_core.sv */
module ooo_core import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      dispatch_valid_i,
  input  dispatch_t dispatch_i,
  output logic      dispatch_ready_o,
  output retire_t   retire_o,
  output logic      flush_o,
  input  arch_reg_t rd_addr_i,
  output word_t     rd_data_o
);

  logic      alloc_valid;
  dispatch_t alloc_entry;
  rob_idx_t  alloc_idx;
  logic      rob_full;
  exe_req_t  alu_req;
  exe_req_t  mdu_req;
  logic      mdu_busy;
  cmt_t      alu_cmt;
  cmt_t      mdu_cmt;

  // ======================================================================
  // dispatch
  // ======================================================================
  dispatch_stage u_dispatch_stage (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .dispatch_valid_i (dispatch_valid_i),
    .dispatch_i       (dispatch_i),
    .rob_full_i       (rob_full),
    .alloc_idx_i      (alloc_idx),
    .mdu_busy_i       (mdu_busy),
    .flush_i          (flush_o),
    .dispatch_ready_o (dispatch_ready_o),
    .alloc_valid_o    (alloc_valid),
    .alloc_entry_o    (alloc_entry),
    .alu_req_o        (alu_req),
    .mdu_req_o        (mdu_req)
  );

  // ======================================================================
  // execute lanes
  // ======================================================================
  alu_unit u_alu_unit (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (alu_req),
    .flush_i (flush_o),
    .cmt_o   (alu_cmt)
  );

  mdu_unit u_mdu_unit (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (mdu_req),
    .flush_i (flush_o),
    .busy_o  (mdu_busy),
    .cmt_o   (mdu_cmt)
  );

  // ======================================================================
  // reorder buffer and retire
  // ======================================================================
  reorder_buffer u_reorder_buffer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .alloc_valid_i (alloc_valid),
    .alloc_entry_i (alloc_entry),
    .alu_cmt_i     (alu_cmt),
    .mdu_cmt_i     (mdu_cmt),
    .alloc_idx_o   (alloc_idx),
    .rob_full_o    (rob_full),
    .retire_o      (retire_o),
    .flush_o       (flush_o)
  );

  arch_reg_file u_arch_reg_file (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .retire_i  (retire_o),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

endmodule

/* testbench/core_checker.sv */
`include "core_macros.svh"

module core_checker import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      dispatch_valid_i,
  input  dispatch_t dispatch_i,
  input  logic      dispatch_ready_i,
  input  retire_t   retire_i,
  input  logic      flush_i,
  input  arch_reg_t rd_addr_i,
  input  word_t     rd_data_i,
  input  logic      rd_check_i,
  output int        error_count_o,
  output int        retired_count_o,
  output int        pending_o,
  output int        flush_count_o
);

  // accepted ops, oldest first
  dispatch_t expected_q [$];
  word_t     model_regs [`CORE_ARCH_REGS];
  int        errors  = 0;
  int        retired = 0;
  int        flushes = 0;

  function automatic word_t ref_value(input dispatch_t op);
    logic [63:0] product;
    word_t       a;
    word_t       b;
    word_t       value;
    a = op.src0;
    b = op.src1;
    case (op.op)
      OP_ADD: value = a + b;
      OP_SUB: value = a - b;
      OP_AND: value = a & b;
      OP_OR:  value = a | b;
      OP_XOR: value = a ^ b;
      // differing signs decide, else plain magnitude order
      OP_SLT: begin
        if (a[`CORE_XLEN-1] != b[`CORE_XLEN-1]) begin
          value = word_t'(a[`CORE_XLEN-1]);
        end else begin
          value = word_t'(a < b);
        end
      end
      OP_MUL: begin
        product = 64'(a) * 64'(b);
        value   = product[31:0];
      end
      default: value = '0;
    endcase
    return value;
  endfunction

  task automatic compare_field(input string name, input word_t pc, input word_t expected,
                               input word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s at pc 0x%08h: expected 0x%08h, got 0x%08h",
               name, pc, expected, actual);
    end
  endtask

  task automatic check_retire();
    dispatch_t exp;
    word_t     exp_value;
    logic      exp_trap;
    if (expected_q.size() == 0) begin
      errors++;
      $display("op at pc 0x%08h retired with no accepted op outstanding", retire_i.pc);
    end else begin
      exp       = expected_q.pop_front();
      exp_value = ref_value(exp);
      exp_trap  = exp.op == OP_TRAP;
      compare_field("retire_o.pc", exp.pc, exp.pc, retire_i.pc);
      compare_field("retire_o.dest_valid", exp.pc, word_t'(exp.dest_valid),
                    word_t'(retire_i.dest_valid));
      compare_field("retire_o.arch_dest", exp.pc, word_t'(exp.arch_dest),
                    word_t'(retire_i.arch_dest));
      compare_field("retire_o.value", exp.pc, exp_value, retire_i.value);
      compare_field("retire_o.exception", exp.pc, word_t'(exp_trap), word_t'(retire_i.exception));
      compare_field("flush_o", exp.pc, word_t'(exp_trap), word_t'(flush_i));
      retired++;
      if (exp_trap) begin
        // everything younger than the trap is gone
        flushes++;
        expected_q.delete();
      end else if (exp.dest_valid) begin
        model_regs[exp.arch_dest] = exp_value;
      end
    end
  endtask

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      expected_q.delete();
      for (int i = 0; i < `CORE_ARCH_REGS; i++) begin
        model_regs[i] = '0;
      end
    end else begin
      if (retire_i.valid) begin
        check_retire();
      end else if (flush_i) begin
        errors++;
        $display("flush_o pulsed without a retiring op");
      end
      if (flush_i && dispatch_ready_i) begin
        errors++;
        $display("dispatch_ready_o was high in a flush cycle");
      end
      if (dispatch_valid_i && dispatch_ready_i) begin
        expected_q.push_back(dispatch_i);
      end
      if (rd_check_i && rd_data_i !== model_regs[rd_addr_i]) begin
        errors++;
        $display("Mismatch rd_data_o for register %0d: expected 0x%08h, got 0x%08h",
                 rd_addr_i, model_regs[rd_addr_i], rd_data_i);
      end
    end
    error_count_o   <= errors;
    retired_count_o <= retired;
    pending_o       <= expected_q.size();
    flush_count_o   <= flushes;
  end

endmodule

/* testbench/tb_ooo_core.sv */
`include "core_macros.svh"

module tb_ooo_core import core_pkg::*; ();

  localparam int SEED          = 59;
  localparam int RANDOM_OPS    = 200;
  localparam int MUL_RUN_OPS   = 40;
  localparam int MUL_PERCENT   = 30;
  localparam int READY_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT = 2000;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      dispatch_valid;
  dispatch_t dispatch;
  logic      dispatch_ready;
  retire_t   retire;
  logic      flush;
  arch_reg_t rd_addr;
  word_t     rd_data;
  logic      rd_check;

  int        error_count;
  int        retired_count;
  int        pending;
  int        flush_count;
  int        tb_errors;
  int        tests_run;
  int        tests_failed;
  logic      timed_out;
  logic      stall_seen;
  word_t     next_pc;

  always #5 clk = ~clk;

  ooo_core ooo_core_i (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .dispatch_valid_i (dispatch_valid),
    .dispatch_i       (dispatch),
    .dispatch_ready_o (dispatch_ready),
    .retire_o         (retire),
    .flush_o          (flush),
    .rd_addr_i        (rd_addr),
    .rd_data_o        (rd_data)
  );

  core_checker u_core_checker (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .dispatch_valid_i (dispatch_valid),
    .dispatch_i       (dispatch),
    .dispatch_ready_i (dispatch_ready),
    .retire_i         (retire),
    .flush_i          (flush),
    .rd_addr_i        (rd_addr),
    .rd_data_i        (rd_data),
    .rd_check_i       (rd_check),
    .error_count_o    (error_count),
    .retired_count_o  (retired_count),
    .pending_o        (pending),
    .flush_count_o    (flush_count)
  );

  // ======================================================================
  // stimulus helpers
  // ======================================================================
  function automatic dispatch_t make_op(input op_e op, input word_t pc);
    dispatch_t d;
    d.op         = op;
    d.pc         = pc;
    d.dest_valid = $urandom_range(0, 7) != 0;
    d.arch_dest  = arch_reg_t'($urandom_range(0, `CORE_ARCH_REGS - 1));
    d.src0       = $urandom;
    d.src1       = $urandom;
    return d;
  endfunction

  // add..slt or a multiply, never a trap
  function automatic op_e random_op();
    if ($urandom_range(0, 99) < MUL_PERCENT) begin
      return OP_MUL;
    end
    return op_e'(3'($urandom_range(0, 5)));
  endfunction

  // call on a rising edge, returns on the edge where the op is taken
  task automatic send_op(input op_e op);
    int waited;
    if (!timed_out) begin
      dispatch_valid <= 1'b1;
      dispatch       <= make_op(op, next_pc);
      next_pc = next_pc + 32'd4;
      waited  = 0;
      do begin
        @(posedge clk);
        waited++;
        if (!dispatch_ready) begin
          stall_seen = 1'b1;
        end
      end while (!dispatch_ready && waited < READY_TIMEOUT);
      if (!dispatch_ready) begin
        $display("dispatch_ready_o stayed low for %0d cycles", READY_TIMEOUT);
        tb_errors++;
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic idle(input int cycles);
    dispatch_valid <= 1'b0;
    repeat (cycles) @(posedge clk);
  endtask

  task automatic drain();
    int waited;
    dispatch_valid <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (pending != 0 && waited < DRAIN_TIMEOUT && !timed_out);
    if (pending != 0 && !timed_out) begin
      $display("%0d ops still in flight after %0d cycles", pending, DRAIN_TIMEOUT);
      tb_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    int errs;
    errs = error_count + tb_errors - errors_before;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %s: %0d errors, %0d ops retired so far", name, errs, retired_count);
  endtask

  // ======================================================================
  // test sequence
  // ======================================================================
  initial begin
    int seed_value;
    int start;
    int flushes_before;
    int waited;
    rst_n          = 1'b0;
    dispatch_valid = 1'b0;
    dispatch       = '0;
    rd_addr        = '0;
    rd_check       = 1'b0;
    tb_errors      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    timed_out      = 1'b0;
    stall_seen     = 1'b0;
    next_pc        = 32'h0000_1000;
    seed_value     = $urandom(SEED);

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (!dispatch_ready || retire.valid || flush) begin
      $display("core is not idle after reset");
      tb_errors++;
    end

    // alu and mdu mixed, completions out of order
    start = error_count + tb_errors;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      send_op(random_op());
      if ($urandom_range(0, 7) == 0) begin
        idle(int'($urandom_range(1, 3)));
      end
    end
    drain();
    report_test("random_mix", start);

    start      = error_count + tb_errors;
    stall_seen = 1'b0;
    for (int i = 0; i < MUL_RUN_OPS; i++) begin
      send_op(OP_MUL);
    end
    drain();
    if (!stall_seen) begin
      $display("dispatch_ready_o never went low during the multiply burst");
      tb_errors++;
    end
    report_test("mul_burst", start);

    // trap with younger ops queued behind it
    start          = error_count + tb_errors;
    flushes_before = flush_count;
    repeat (6) send_op(random_op());
    send_op(OP_TRAP);
    repeat (6) send_op(random_op());
    dispatch_valid <= 1'b0;
    waited = 0;
    while (flush_count == flushes_before && waited < DRAIN_TIMEOUT && !timed_out) begin
      @(posedge clk);
      waited++;
    end
    for (int i = 0; i < 10; i++) begin
      send_op(random_op());
    end
    drain();
    if (flush_count != flushes_before + 1) begin
      $display("expected one flush, saw %0d", flush_count - flushes_before);
      tb_errors++;
    end
    report_test("trap_flush", start);

    start = error_count + tb_errors;
    for (int i = 0; i < `CORE_ARCH_REGS; i++) begin
      rd_addr  <= arch_reg_t'(i);
      rd_check <= 1'b1;
      @(posedge clk);
    end
    rd_check <= 1'b0;
    @(posedge clk);
    report_test("reg_readback", start);

    $display("tests run %0d, tests failed %0d, ops retired %0d, flushes %0d, errors %0d",
             tests_run, tests_failed, retired_count, flush_count, error_count + tb_errors);
    if (error_count == 0 && tb_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* ooo_core.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/dispatch_stage.sv
verilog/alu_unit.sv
verilog/mdu_unit.sv
verilog/reorder_buffer.sv
verilog/arch_reg_file.sv
verilog/ooo_core.sv
testbench/core_checker.sv
testbench/tb_ooo_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ooo_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ooo_core -f ooo_core.f -o sim_ooo_core

./obj_dir/sim_ooo_core > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
